//--- insn_decoder.sv
////////////////////////////////////////
// Single-lane instruction decoder
// Classifies one retired word into a kind,
// an access mask and an immediate or target,
// registered with the rest of the record
////////////////////////////////////////

`timescale 1ns/100ps

`include "rvfi_tracer_params.svh"

module insn_decoder import rvfi_tracer_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    lane_valid,
  input  logic [`TRC_XLEN-1:0]    lane_insn,
  input  logic [`TRC_XLEN-1:0]    lane_pc,
  input  logic [4:0]              lane_rd_addr,
  input  logic [`TRC_XLEN-1:0]    lane_rd_wdata,
  input  logic [`TRC_CYCLE_W-1:0] lane_cycle,

  output logic                    dec_valid,
  output logic [`TRC_CYCLE_W-1:0] dec_cycle,
  output logic [`TRC_XLEN-1:0]    dec_pc,
  output logic [`TRC_XLEN-1:0]    dec_insn,
  output trace_kind_e             dec_kind,
  output access_t                 dec_access,
  output logic [`TRC_XLEN-1:0]    dec_imm,
  output logic [4:0]              dec_rd_addr,
  output logic [`TRC_XLEN-1:0]    dec_rd_wdata
);

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`TRC_XLEN-1:0] imm_i;
  logic [`TRC_XLEN-1:0] imm_s;
  logic [`TRC_XLEN-1:0] imm_b;
  logic [`TRC_XLEN-1:0] imm_j;
  logic [`TRC_XLEN-1:0] imm_u;

  trace_kind_e          kind_d;
  access_t              acc_d;
  logic [`TRC_XLEN-1:0] imm_d;

  assign opcode = lane_insn[6:0];
  assign funct3 = lane_insn[14:12];
  assign funct7 = lane_insn[31:25];

  ////////////////////////////////////////
  // Immediate formats
  ////////////////////////////////////////
  assign imm_i = {{20{lane_insn[31]}}, lane_insn[31:20]};
  assign imm_s = {{20{lane_insn[31]}}, lane_insn[31:25], lane_insn[11:7]};
  assign imm_b = {{19{lane_insn[31]}}, lane_insn[31], lane_insn[7],
                  lane_insn[30:25], lane_insn[11:8], 1'b0};
  assign imm_j = {{11{lane_insn[31]}}, lane_insn[31], lane_insn[19:12],
                  lane_insn[20], lane_insn[30:21], 1'b0};
  assign imm_u = {lane_insn[31:12], 12'b0};

  ////////////////////////////////////////
  // Kind, access mask and immediate
  ////////////////////////////////////////
  always_comb begin
    kind_d = KIND_INVALID;
    acc_d  = '0;
    imm_d  = '0;
    if (lane_insn[1:0] != 2'b11) begin
      // Compressed words are only marked
      kind_d = KIND_COMPRESSED;
    end else begin
      case (opcode)
        OPC_LUI: begin
          kind_d   = KIND_LUI;
          acc_d.rd = 1'b1;
          imm_d    = imm_u;
        end
        OPC_AUIPC: begin
          kind_d   = KIND_AUIPC;
          acc_d.rd = 1'b1;
          imm_d    = imm_u;
        end
        OPC_JAL: begin
          kind_d   = KIND_JAL;
          acc_d.rd = 1'b1;
          imm_d    = lane_pc + imm_j;
        end
        OPC_JALR: begin
          kind_d    = KIND_JALR;
          acc_d.rs1 = 1'b1;
          acc_d.rd  = 1'b1;
          imm_d     = imm_i;
        end
        OPC_BRANCH: begin
          kind_d    = KIND_BRANCH;
          acc_d.rs1 = 1'b1;
          acc_d.rs2 = 1'b1;
          imm_d     = lane_pc + imm_b;
        end
        OPC_LOAD: begin
          // Sizes 3, 6 and 7 do not exist
          if (funct3 != 3'd3 && funct3 < 3'd6) begin
            kind_d    = KIND_LOAD;
            acc_d.rs1 = 1'b1;
            acc_d.rd  = 1'b1;
            acc_d.mem = 1'b1;
            imm_d     = imm_i;
          end
        end
        OPC_STORE: begin
          // Only byte, half and word stores
          if (!funct3[2] && funct3 != 3'd3) begin
            kind_d    = KIND_STORE;
            acc_d.rs1 = 1'b1;
            acc_d.rs2 = 1'b1;
            acc_d.mem = 1'b1;
            imm_d     = imm_s;
          end
        end
        OPC_OP_IMM: begin
          kind_d    = KIND_OP_IMM;
          acc_d.rs1 = 1'b1;
          acc_d.rd  = 1'b1;
          if (funct3 == 3'd1 || funct3 == 3'd5) begin
            imm_d = {27'b0, lane_insn[24:20]};
          end else begin
            imm_d = imm_i;
          end
        end
        OPC_OP: begin
          kind_d    = (funct7 == 7'd1) ? KIND_MULDIV : KIND_OP;
          acc_d.rs1 = 1'b1;
          acc_d.rs2 = 1'b1;
          acc_d.rd  = 1'b1;
        end
        OPC_SYSTEM: begin
          if (funct3 == 3'd0) begin
            kind_d = KIND_SYSTEM;
          end else begin
            // Immediate forms carry no rs1
            kind_d    = KIND_CSR;
            acc_d.rd  = 1'b1;
            acc_d.rs1 = !funct3[2];
            imm_d     = {20'b0, lane_insn[31:20]};
          end
        end
        OPC_MISC_MEM: begin
          kind_d = KIND_FENCE;
        end
        default: begin
          kind_d = KIND_INVALID;
        end
      endcase
    end
    // Writes to x0 are not reported
    if (lane_rd_addr == 5'd0) begin
      acc_d.rd = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= lane_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    dec_cycle    <= lane_cycle;
    dec_pc       <= lane_pc;
    dec_insn     <= lane_insn;
    dec_kind     <= kind_d;
    dec_access   <= acc_d;
    dec_imm      <= imm_d;
    dec_rd_addr  <= lane_rd_addr;
    dec_rd_wdata <= lane_rd_wdata;
  end

  // Full-size words never leave as compressed
  a_no_false_compressed: assert property (
    @(posedge clk_i) disable iff (rst_ni)
    dec_valid && dec_insn[1:0] == 2'b11 |-> dec_kind != KIND_COMPRESSED
  );

endmodule

//--- rvfi_tracer.f
+incdir+.
rvfi_tracer_pkg.sv
trace_unpack.sv
insn_decoder.sv
trace_merge.sv
rvfi_tracer.sv
tb_rvfi_tracer.sv

//--- rvfi_tracer.sv
////////////////////////////////////////
// Retirement tracer top level
// RVFI in, decoded trace records out on a
// valid/ready stream in program order
////////////////////////////////////////

`timescale 1ns/100ps

`include "rvfi_tracer_params.svh"

module rvfi_tracer import rvfi_tracer_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  input  logic [`TRC_LANES-1:0]           rvfi_valid,
  input  logic [`TRC_LANES*`TRC_XLEN-1:0] rvfi_insn,
  input  logic [`TRC_LANES*`TRC_XLEN-1:0] rvfi_pc_rdata,
  input  logic [`TRC_LANES*5-1:0]         rvfi_rd_addr,
  input  logic [`TRC_LANES*`TRC_XLEN-1:0] rvfi_rd_wdata,

  input  logic                            trc_ready,
  output logic                            trc_valid,
  output logic [`TRC_CYCLE_W-1:0]         trc_cycle,
  output logic [`TRC_XLEN-1:0]            trc_pc,
  output logic [`TRC_XLEN-1:0]            trc_insn,
  output trace_kind_e                     trc_kind,
  output access_t                         trc_access,
  output logic [`TRC_XLEN-1:0]            trc_imm,
  output logic [4:0]                      trc_rd_addr,
  output logic [`TRC_XLEN-1:0]            trc_rd_wdata,
  output logic                            trc_overflow
);

  // Unpacked lanes
  logic [`TRC_LANES-1:0]   lane_valid;
  logic [`TRC_XLEN-1:0]    lane_insn     [`TRC_LANES];
  logic [`TRC_XLEN-1:0]    lane_pc       [`TRC_LANES];
  logic [4:0]              lane_rd_addr  [`TRC_LANES];
  logic [`TRC_XLEN-1:0]    lane_rd_wdata [`TRC_LANES];
  logic [`TRC_CYCLE_W-1:0] lane_cycle;

  // Decoded lanes
  logic [`TRC_LANES-1:0]   dec_valid;
  logic [`TRC_CYCLE_W-1:0] dec_cycle    [`TRC_LANES];
  logic [`TRC_XLEN-1:0]    dec_pc       [`TRC_LANES];
  logic [`TRC_XLEN-1:0]    dec_insn     [`TRC_LANES];
  trace_kind_e             dec_kind     [`TRC_LANES];
  access_t                 dec_access   [`TRC_LANES];
  logic [`TRC_XLEN-1:0]    dec_imm      [`TRC_LANES];
  logic [4:0]              dec_rd_addr  [`TRC_LANES];
  logic [`TRC_XLEN-1:0]    dec_rd_wdata [`TRC_LANES];

  trace_unpack u_unpack (
    .clk_i, .rst_ni,
    .rvfi_valid, .rvfi_insn, .rvfi_pc_rdata, .rvfi_rd_addr, .rvfi_rd_wdata,
    .lane_valid, .lane_insn, .lane_pc, .lane_rd_addr, .lane_rd_wdata, .lane_cycle
  );

  for (genvar l = 0; l < `TRC_LANES; l++) begin : g_lane
    insn_decoder u_dec (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .lane_valid    (lane_valid[l]),
      .lane_insn     (lane_insn[l]),
      .lane_pc       (lane_pc[l]),
      .lane_rd_addr  (lane_rd_addr[l]),
      .lane_rd_wdata (lane_rd_wdata[l]),
      .lane_cycle    (lane_cycle),
      .dec_valid     (dec_valid[l]),
      .dec_cycle     (dec_cycle[l]),
      .dec_pc        (dec_pc[l]),
      .dec_insn      (dec_insn[l]),
      .dec_kind      (dec_kind[l]),
      .dec_access    (dec_access[l]),
      .dec_imm       (dec_imm[l]),
      .dec_rd_addr   (dec_rd_addr[l]),
      .dec_rd_wdata  (dec_rd_wdata[l])
    );
  end

  trace_merge u_merge (
    .clk_i, .rst_ni,
    .dec_valid, .dec_cycle, .dec_pc, .dec_insn, .dec_kind, .dec_access,
    .dec_imm, .dec_rd_addr, .dec_rd_wdata,
    .trc_ready, .trc_valid, .trc_cycle, .trc_pc, .trc_insn, .trc_kind,
    .trc_access, .trc_imm, .trc_rd_addr, .trc_rd_wdata, .trc_overflow
  );

endmodule

//--- rvfi_tracer_params.svh
////////////////////////////////////////
// Build-time sizes of the retirement tracer
// Include in every RTL file that sizes ports
// or storage by lane count or data width
////////////////////////////////////////

`ifndef RVFI_TRACER_PARAMS_SVH
`define RVFI_TRACER_PARAMS_SVH

// Retirement lanes of the core
`define TRC_LANES 2

// Data and PC width
`define TRC_XLEN 32

// Cycle stamp width
`define TRC_CYCLE_W 32

// Merge FIFO slots as a power of two
`define TRC_FIFO_DEPTH 8

`endif

//--- rvfi_tracer_pkg.sv
////////////////////////////////////////
// Shared types of the retirement tracer
// Instruction kinds, access mask and the
// RISC-V major opcodes used by the decoder
////////////////////////////////////////

package rvfi_tracer_pkg;

  // Instruction kind carried in each record
  typedef enum logic [3:0] {
    KIND_LUI,
    KIND_AUIPC,
    KIND_JAL,
    KIND_JALR,
    KIND_BRANCH,
    KIND_LOAD,
    KIND_STORE,
    KIND_OP_IMM,
    KIND_OP,
    KIND_MULDIV,
    KIND_CSR,
    KIND_SYSTEM,
    KIND_FENCE,
    KIND_COMPRESSED,
    KIND_INVALID
  } trace_kind_e;

  // Items touched by an instruction with rs1 in bit 0
  typedef struct packed {
    logic mem;
    logic rd;
    logic rs2;
    logic rs1;
  } access_t;

  ////////////////////////////////////////
  // Major opcodes in insn[6:0]
  ////////////////////////////////////////
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

endpackage

//--- tb_trace_model.svh
////////////////////////////////////////
// Reference model for the tracer testbench
// Decode rules per record and the queue of
// records expected on the output stream
////////////////////////////////////////

`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

typedef struct packed {
  logic [31:0] cycle;
  logic [31:0] pc;
  logic [31:0] insn;
  trace_kind_e kind;
  access_t     access;
  logic [31:0] imm;
  logic [4:0]  rd_addr;
  logic [31:0] rd_wdata;
} exp_rec_t;

// Records admitted to the FIFO with the oldest first
exp_rec_t exp_q[$];

function automatic trace_kind_e decode_kind(input logic [31:0] insn);
  logic [2:0] f3;
  f3 = insn[14:12];
  if (insn[1:0] != 2'b11) return KIND_COMPRESSED;
  case (insn[6:0])
    OPC_LUI:      return KIND_LUI;
    OPC_AUIPC:    return KIND_AUIPC;
    OPC_JAL:      return KIND_JAL;
    OPC_JALR:     return KIND_JALR;
    OPC_BRANCH:   return KIND_BRANCH;
    OPC_LOAD:     return (f3 == 3'd3 || f3 >= 3'd6) ? KIND_INVALID : KIND_LOAD;
    OPC_STORE:    return (f3 >= 3'd3) ? KIND_INVALID : KIND_STORE;
    OPC_OP_IMM:   return KIND_OP_IMM;
    OPC_OP:       return (insn[31:25] == 7'd1) ? KIND_MULDIV : KIND_OP;
    OPC_SYSTEM:   return (f3 == 3'd0) ? KIND_SYSTEM : KIND_CSR;
    OPC_MISC_MEM: return KIND_FENCE;
    default:      return KIND_INVALID;
  endcase
endfunction

// Mask bits are mem, rd, rs2, rs1 from the top
function automatic access_t decode_access(input trace_kind_e kind, input logic [31:0] insn,
                                          input logic [4:0] rd);
  access_t a;
  case (kind)
    KIND_OP, KIND_MULDIV:        a = access_t'(4'b0111);
    KIND_OP_IMM, KIND_JALR:      a = access_t'(4'b0101);
    KIND_LOAD:                   a = access_t'(4'b1101);
    KIND_LUI, KIND_AUIPC, KIND_JAL: a = access_t'(4'b0100);
    KIND_BRANCH:                 a = access_t'(4'b0011);
    KIND_STORE:                  a = access_t'(4'b1011);
    KIND_CSR:                    a = access_t'({3'b010, ~insn[14]});
    default:                     a = access_t'(4'b0000);
  endcase
  if (rd == 5'd0) a.rd = 1'b0;
  return a;
endfunction

function automatic logic [31:0] decode_imm(input trace_kind_e kind, input logic [31:0] insn,
                                           input logic [31:0] pc);
  logic [20:0] off_j;
  logic [12:0] off_b;
  off_j = {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  off_b = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  case (kind)
    KIND_LUI, KIND_AUIPC: return {insn[31:12], 12'h000};
    KIND_JAL:             return pc + {{11{off_j[20]}}, off_j};
    KIND_BRANCH:          return pc + {{19{off_b[12]}}, off_b};
    KIND_JALR, KIND_LOAD: return {{20{insn[31]}}, insn[31:20]};
    // funct3 of 1 and 5 are the shifts
    KIND_OP_IMM: return (insn[13:12] == 2'b01) ? {27'h0, insn[24:20]}
                                               : {{20{insn[31]}}, insn[31:20]};
    KIND_STORE:           return {{20{insn[31]}}, insn[31:25], insn[11:7]};
    KIND_CSR:             return {20'h0, insn[31:20]};
    default:              return 32'h0;
  endcase
endfunction

function automatic exp_rec_t make_record(input logic [31:0] cycle, input logic [31:0] pc,
                                         input logic [31:0] insn, input logic [4:0] rd,
                                         input logic [31:0] wdata);
  exp_rec_t r;
  r.cycle    = cycle;
  r.pc       = pc;
  r.insn     = insn;
  r.kind     = decode_kind(insn);
  r.access   = decode_access(r.kind, insn, rd);
  r.imm      = decode_imm(r.kind, insn, pc);
  r.rd_addr  = rd;
  r.rd_wdata = wdata;
  return r;
endfunction

`endif

//--- tb_rvfi_tracer.sv
////////////////////////////////////////
// Testbench of the retirement tracer
// Random two-lane retirements checked record
// by record against a reference model
////////////////////////////////////////

`timescale 1ns/100ps

`include "rvfi_tracer_params.svh"

module tb_rvfi_tracer import rvfi_tracer_pkg::*; ();

  `include "tb_trace_model.svh"

  localparam int P1_CYCLES   = 400;
  localparam int P2_CYCLES   = 200;
  localparam int P3_CYCLES   = 12;
  localparam int STIM_CYCLES = P1_CYCLES + P2_CYCLES + P3_CYCLES;
  localparam int LIMIT       = STIM_CYCLES * 4 + 100;

  logic                            clk_i;
  logic                            rst_ni;
  logic [`TRC_LANES-1:0]           rvfi_valid;
  logic [`TRC_LANES*`TRC_XLEN-1:0] rvfi_insn;
  logic [`TRC_LANES*`TRC_XLEN-1:0] rvfi_pc_rdata;
  logic [`TRC_LANES*5-1:0]         rvfi_rd_addr;
  logic [`TRC_LANES*`TRC_XLEN-1:0] rvfi_rd_wdata;
  logic                            trc_ready;
  logic                            trc_valid;
  logic [`TRC_CYCLE_W-1:0]         trc_cycle;
  logic [`TRC_XLEN-1:0]            trc_pc;
  logic [`TRC_XLEN-1:0]            trc_insn;
  trace_kind_e                     trc_kind;
  access_t                         trc_access;
  logic [`TRC_XLEN-1:0]            trc_imm;
  logic [4:0]                      trc_rd_addr;
  logic [`TRC_XLEN-1:0]            trc_rd_wdata;
  logic                            trc_overflow;

  integer        seed;
  int unsigned   edges = 0;
  logic [31:0]   cycle_m;
  logic [31:0]   last_cycle;
  logic          ovf_m;
  // One model stage per register in front of the FIFO
  exp_rec_t              s1 [`TRC_LANES];
  exp_rec_t              s2 [`TRC_LANES];
  logic [`TRC_LANES-1:0] s1_v;
  logic [`TRC_LANES-1:0] s2_v;

  rvfi_tracer u_dut (
    .clk_i, .rst_ni,
    .rvfi_valid, .rvfi_insn, .rvfi_pc_rdata, .rvfi_rd_addr, .rvfi_rd_wdata,
    .trc_ready, .trc_valid, .trc_cycle, .trc_pc, .trc_insn, .trc_kind,
    .trc_access, .trc_imm, .trc_rd_addr, .trc_rd_wdata, .trc_overflow
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    edges = edges + 1;
    if (edges > LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      report_failure();
    end
  end

  task automatic report_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_kind(input string name, input trace_kind_e exp, input trace_kind_e act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_access(input string name, input access_t exp, input access_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      report_failure();
    end
  endtask

  // Random fields over every major opcode plus compressed and unknown words
  function automatic logic [31:0] random_insn();
    logic [31:0] w;
    int          sel;
    w   = $random(seed);
    sel = ($random(seed) & 32'h7fff_ffff) % 14;
    if (($random(seed) & 7) == 0) w[11:7] = 5'd0;
    case (sel)
      0:  w[6:0] = OPC_LUI;
      1:  w[6:0] = OPC_AUIPC;
      2:  w[6:0] = OPC_JAL;
      3:  w[6:0] = OPC_JALR;
      4:  w[6:0] = OPC_BRANCH;
      5:  w[6:0] = OPC_LOAD;
      6:  w[6:0] = OPC_STORE;
      7:  w[6:0] = OPC_OP_IMM;
      8:  w[6:0] = OPC_OP;
      9:  w[6:0] = OPC_SYSTEM;
      10: w[6:0] = OPC_MISC_MEM;
      11: begin
        w[6:0]   = OPC_OP;
        w[31:25] = 7'd1;
      end
      12: w[1:0] = (w[1:0] == 2'b11) ? 2'b10 : w[1:0];
      default: w[6:0] = w[20] ? 7'b1011011 : 7'b0101111;
    endcase
    return w;
  endfunction

  // Each lane valid with odds of one in n
  function automatic logic [`TRC_LANES-1:0] valid_mask(input int n);
    logic [`TRC_LANES-1:0] m;
    for (int l = 0; l < `TRC_LANES; l++) begin
      m[l] = (($random(seed) & 32'h7fff_ffff) % n) == 0;
    end
    return m;
  endfunction

  // Check the head, model the next edge and drive new inputs
  task automatic step(input logic [`TRC_LANES-1:0] vld, input logic rdy);
    exp_rec_t    head;
    logic [31:0] insn;
    logic [31:0] pc;
    logic [31:0] wdata;
    int          n;
    @(negedge clk_i);
    cycle_m = cycle_m + 1;
    check_bit("trc_valid", exp_q.size() != 0, trc_valid);
    check_bit("trc_overflow", ovf_m, trc_overflow);
    if (exp_q.size() != 0) begin
      head = exp_q[0];
      check_word("trc_cycle", head.cycle, trc_cycle);
      check_word("trc_pc", head.pc, trc_pc);
      check_word("trc_insn", head.insn, trc_insn);
      check_kind("trc_kind", head.kind, trc_kind);
      check_access("trc_access", head.access, trc_access);
      check_word("trc_imm", head.imm, trc_imm);
      check_reg("trc_rd_addr", head.rd_addr, trc_rd_addr);
      check_word("trc_rd_wdata", head.rd_wdata, trc_rd_wdata);
    end
    // Admission sees the occupancy before this edge's pop
    n = 0;
    for (int l = 0; l < `TRC_LANES; l++) begin
      if (s2_v[l]) n = n + 1;
    end
    if (n > `TRC_FIFO_DEPTH - exp_q.size()) begin
      ovf_m = 1'b1;
      n     = 0;
    end
    // The ready driven below is the one sampled at the next edge
    if (trc_valid && rdy) begin
      if (trc_cycle < last_cycle) begin
        $display("Cycle stamp went backwards from %h to %h", last_cycle, trc_cycle);
        report_failure();
      end
      last_cycle = trc_cycle;
      head       = exp_q.pop_front();
    end
    for (int l = 0; l < `TRC_LANES; l++) begin
      if (n != 0 && s2_v[l]) exp_q.push_back(s2[l]);
      s2[l] = s1[l];
    end
    s2_v = s1_v;
    for (int l = 0; l < `TRC_LANES; l++) begin
      insn  = random_insn();
      pc    = $random(seed) & 32'hffff_fffc;
      wdata = $random(seed);
      rvfi_insn[l*`TRC_XLEN +: `TRC_XLEN]     = insn;
      rvfi_pc_rdata[l*`TRC_XLEN +: `TRC_XLEN] = pc;
      rvfi_rd_addr[l*5 +: 5]                  = insn[11:7];
      rvfi_rd_wdata[l*`TRC_XLEN +: `TRC_XLEN] = wdata;
      s1[l] = make_record(cycle_m, pc, insn, insn[11:7], wdata);
    end
    rvfi_valid = vld;
    s1_v       = vld;
    trc_ready  = rdy;
  endtask

  initial begin
    seed          = 32'h54f2;
    rst_ni        = 1'b1;
    rvfi_valid    = '0;
    rvfi_insn     = '0;
    rvfi_pc_rdata = '0;
    rvfi_rd_addr  = '0;
    rvfi_rd_wdata = '0;
    trc_ready     = 1'b0;
    cycle_m       = '0;
    last_cycle    = '0;
    ovf_m         = 1'b0;
    s1_v          = '0;
    s2_v          = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b0;

    // Sparse retirements under random back-pressure
    repeat (P1_CYCLES) step(valid_mask(4), (($random(seed) & 3) != 0));
    // Denser retirements into an always-ready sink
    repeat (P2_CYCLES) step(valid_mask(3), 1'b1);
    // Both lanes every cycle into a stalled sink
    repeat (P3_CYCLES) step('1, 1'b0);

    while (s1_v != '0 || s2_v != '0 || exp_q.size() != 0) begin
      step('0, 1'b1);
    end
    step('0, 1'b1);
    if (!trc_overflow) begin
      $display("Overflow flag did not rise while the sink was stalled");
      report_failure();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- trace_merge.sv
////////////////////////////////////////
// Record FIFO of the tracer
// Takes all valid lanes of a cycle in lane
// order and drains one record per handshake;
// a cycle that does not fit is dropped whole
////////////////////////////////////////

`timescale 1ns/100ps

`include "rvfi_tracer_params.svh"

module trace_merge import rvfi_tracer_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Decoded lanes
  input  logic [`TRC_LANES-1:0]   dec_valid,
  input  logic [`TRC_CYCLE_W-1:0] dec_cycle    [`TRC_LANES],
  input  logic [`TRC_XLEN-1:0]    dec_pc       [`TRC_LANES],
  input  logic [`TRC_XLEN-1:0]    dec_insn     [`TRC_LANES],
  input  trace_kind_e             dec_kind     [`TRC_LANES],
  input  access_t                 dec_access   [`TRC_LANES],
  input  logic [`TRC_XLEN-1:0]    dec_imm      [`TRC_LANES],
  input  logic [4:0]              dec_rd_addr  [`TRC_LANES],
  input  logic [`TRC_XLEN-1:0]    dec_rd_wdata [`TRC_LANES],

  // Output stream
  input  logic                    trc_ready,
  output logic                    trc_valid,
  output logic [`TRC_CYCLE_W-1:0] trc_cycle,
  output logic [`TRC_XLEN-1:0]    trc_pc,
  output logic [`TRC_XLEN-1:0]    trc_insn,
  output trace_kind_e             trc_kind,
  output access_t                 trc_access,
  output logic [`TRC_XLEN-1:0]    trc_imm,
  output logic [4:0]              trc_rd_addr,
  output logic [`TRC_XLEN-1:0]    trc_rd_wdata,
  output logic                    trc_overflow
);

  localparam int unsigned PTR_W = $clog2(`TRC_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(`TRC_FIFO_DEPTH + 1);

  // Record storage
  logic [`TRC_CYCLE_W-1:0] mem_cycle    [`TRC_FIFO_DEPTH];
  logic [`TRC_XLEN-1:0]    mem_pc       [`TRC_FIFO_DEPTH];
  logic [`TRC_XLEN-1:0]    mem_insn     [`TRC_FIFO_DEPTH];
  trace_kind_e             mem_kind     [`TRC_FIFO_DEPTH];
  access_t                 mem_access   [`TRC_FIFO_DEPTH];
  logic [`TRC_XLEN-1:0]    mem_imm      [`TRC_FIFO_DEPTH];
  logic [4:0]              mem_rd_addr  [`TRC_FIFO_DEPTH];
  logic [`TRC_XLEN-1:0]    mem_rd_wdata [`TRC_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] n_push;
  logic [PTR_W-1:0] slot [`TRC_LANES];
  logic             push_ok;
  logic             pop;

  ////////////////////////////////////////
  // Slot assignment and admission
  ////////////////////////////////////////
  always_comb begin
    n_push = '0;
    for (int l = 0; l < `TRC_LANES; l++) begin
      slot[l] = wr_ptr + n_push[PTR_W-1:0];
      n_push  = n_push + CNT_W'(dec_valid[l]);
    end
  end

  // Space freed by a pop in the same cycle is not counted
  assign push_ok = n_push <= (CNT_W'(`TRC_FIFO_DEPTH) - count);
  assign pop     = trc_valid && trc_ready;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      for (int l = 0; l < `TRC_LANES; l++) begin
        if (dec_valid[l]) begin
          mem_cycle[slot[l]]    <= dec_cycle[l];
          mem_pc[slot[l]]       <= dec_pc[l];
          mem_insn[slot[l]]     <= dec_insn[l];
          mem_kind[slot[l]]     <= dec_kind[l];
          mem_access[slot[l]]   <= dec_access[l];
          mem_imm[slot[l]]      <= dec_imm[l];
          mem_rd_addr[slot[l]]  <= dec_rd_addr[l];
          mem_rd_wdata[slot[l]] <= dec_rd_wdata[l];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      trc_overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + n_push[PTR_W-1:0];
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (push_ok ? n_push : '0) - CNT_W'(pop);
      // Sticky until reset
      if (!push_ok) begin
        trc_overflow <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Head of the FIFO
  ////////////////////////////////////////
  assign trc_valid    = count != '0;
  assign trc_cycle    = mem_cycle[rd_ptr];
  assign trc_pc       = mem_pc[rd_ptr];
  assign trc_insn     = mem_insn[rd_ptr];
  assign trc_kind     = mem_kind[rd_ptr];
  assign trc_access   = mem_access[rd_ptr];
  assign trc_imm      = mem_imm[rd_ptr];
  assign trc_rd_addr  = mem_rd_addr[rd_ptr];
  assign trc_rd_wdata = mem_rd_wdata[rd_ptr];

  // Stalled record holds until taken
  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (rst_ni)
    trc_valid && !trc_ready |=> trc_valid && $stable(trc_cycle) && $stable(trc_pc)
      && $stable(trc_insn) && $stable(trc_kind) && $stable(trc_access)
      && $stable(trc_imm) && $stable(trc_rd_addr) && $stable(trc_rd_wdata)
  );

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (rst_ni)
    count <= CNT_W'(`TRC_FIFO_DEPTH)
  );

endmodule

//--- trace_unpack.sv
////////////////////////////////////////
// RVFI input stage of the tracer
// Samples the packed retirement ports every
// clock and splits them into lane fields,
// each stamped with the cycle count
////////////////////////////////////////

`timescale 1ns/100ps

`include "rvfi_tracer_params.svh"

module trace_unpack import rvfi_tracer_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Packed RVFI, lane 0 in the low slice
  input  logic [`TRC_LANES-1:0]                 rvfi_valid,
  input  logic [`TRC_LANES*`TRC_XLEN-1:0]       rvfi_insn,
  input  logic [`TRC_LANES*`TRC_XLEN-1:0]       rvfi_pc_rdata,
  input  logic [`TRC_LANES*5-1:0]               rvfi_rd_addr,
  input  logic [`TRC_LANES*`TRC_XLEN-1:0]       rvfi_rd_wdata,

  // Per-lane fields
  output logic [`TRC_LANES-1:0]                 lane_valid,
  output logic [`TRC_XLEN-1:0]                  lane_insn     [`TRC_LANES],
  output logic [`TRC_XLEN-1:0]                  lane_pc       [`TRC_LANES],
  output logic [4:0]                            lane_rd_addr  [`TRC_LANES],
  output logic [`TRC_XLEN-1:0]                  lane_rd_wdata [`TRC_LANES],
  output logic [`TRC_CYCLE_W-1:0]               lane_cycle
);

  // Cycles since reset release
  logic [`TRC_CYCLE_W-1:0] cycle_q;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // Lane valid bits
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      lane_valid <= '0;
    end else begin
      lane_valid <= rvfi_valid;
    end
  end

  // Stamp with the count held before this edge
  always_ff @(posedge clk_i) begin
    lane_cycle <= cycle_q;
    for (int l = 0; l < `TRC_LANES; l++) begin
      lane_insn[l]     <= rvfi_insn[l*`TRC_XLEN +: `TRC_XLEN];
      lane_pc[l]       <= rvfi_pc_rdata[l*`TRC_XLEN +: `TRC_XLEN];
      lane_rd_addr[l]  <= rvfi_rd_addr[l*5 +: 5];
      lane_rd_wdata[l] <= rvfi_rd_wdata[l*`TRC_XLEN +: `TRC_XLEN];
    end
  end

endmodule
